/* common/sched_pkg.sv */
// scheduler package with shared sizes and the instruction, payload and port types
package sched_pkg;

  // ====================
  // sizes
  // ====================
  localparam int NUM_ARCH_REGS = 32;
  localparam int NUM_PHYS_REGS = 48;
  localparam int DECODE_WIDTH  = 2;
  localparam int WB_WIDTH      = 2;
  localparam int COMMIT_WIDTH  = 2;
  localparam int ALU_RS_DEPTH  = 8;
  localparam int MEM_RS_DEPTH  = 4;
  localparam int TAG_W         = 8;

  // free list holds every physical register not mapped by the table
  localparam int FL_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;
  localparam int FL_PTR_W = $clog2(FL_DEPTH);
  localparam int FL_CNT_W = $clog2(FL_DEPTH + 1);

  // ====================
  // basic types
  // ====================
  typedef logic [4:0] areg_t;
  typedef logic [5:0] preg_t;
  typedef logic [3:0] alu_op_t;
  typedef logic [2:0] mem_op_t;

  typedef enum logic {
    CLASS_ALU = 1'b0,
    CLASS_MEM = 1'b1
  } instr_class_e;

  // decoded instruction, register 0 means no operand
  typedef struct packed {
    logic             valid;
    instr_class_e     cls;
    areg_t            src0;
    areg_t            src1;
    areg_t            dest;
    alu_op_t          alu_op;
    mem_op_t          mem_op;
    logic [TAG_W-1:0] tag;
  } sched_instr_t;

  typedef sched_instr_t [DECODE_WIDTH-1:0] sched_req_t;

  // ====================
  // renamed payloads
  // ====================
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic             src0_valid;
    preg_t            psrc0;
    logic             src0_rdy;
    logic             src1_valid;
    preg_t            psrc1;
    logic             src1_rdy;
    logic             dest_valid;
    preg_t            pdest;
    preg_t            old_pdest;
  } rs_base_t;

  typedef struct packed {
    rs_base_t base;
    alu_op_t  op;
  } alu_payload_t;

  typedef struct packed {
    rs_base_t base;
    mem_op_t  op;
  } mem_payload_t;

  // writeback and commit ports
  typedef struct packed {
    logic  valid;
    preg_t preg;
  } preg_port_t;

  typedef preg_port_t [WB_WIDTH-1:0]     wb_t;
  typedef preg_port_t [COMMIT_WIDTH-1:0] free_t;

endpackage

/* rename/free_list.sv */
// free list FIFO of physical registers with two-wide allocate and two-wide free
`timescale 1ns/1ps

module free_list (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [sched_pkg::DECODE_WIDTH-1:0]            alloc_req_i,
  output logic                                          alloc_ok_o,
  output sched_pkg::preg_t [sched_pkg::DECODE_WIDTH-1:0] alloc_preg_o,
  input  sched_pkg::free_t                              free_i
);
  import sched_pkg::*;

  preg_t [FL_DEPTH-1:0]                 fifo_q;
  logic [FL_PTR_W-1:0]                  head_q;
  logic [FL_PTR_W-1:0]                  tail_q;
  logic [FL_CNT_W-1:0]                  count_q;
  logic [FL_CNT_W-1:0]                  n_alloc;
  logic [FL_CNT_W-1:0]                  n_free;
  logic [COMMIT_WIDTH-1:0][FL_PTR_W-1:0] free_ptr;

  // a full bundle must always find enough registers
  assign alloc_ok_o = count_q >= FL_CNT_W'(DECODE_WIDTH);

  always_comb begin
    // requesting lanes take consecutive entries from the head
    n_alloc = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      alloc_preg_o[i] = fifo_q[head_q + n_alloc[FL_PTR_W-1:0]];
      n_alloc         = n_alloc + FL_CNT_W'(alloc_req_i[i]);
    end

    // frees land at the tail in port order
    n_free = '0;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      free_ptr[i] = tail_q + n_free[FL_PTR_W-1:0];
      n_free      = n_free + FL_CNT_W'(free_i[i].valid);
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= FL_CNT_W'(FL_DEPTH);
      for (int i = 0; i < FL_DEPTH; i++) begin
        fifo_q[i] <= preg_t'(NUM_ARCH_REGS + i);
      end
    end else begin
      head_q  <= head_q + n_alloc[FL_PTR_W-1:0];
      tail_q  <= tail_q + n_free[FL_PTR_W-1:0];
      count_q <= count_q + n_free - n_alloc;
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (free_i[i].valid) begin
          fifo_q[free_ptr[i]] <= free_i[i].preg;
        end
      end
    end
  end

endmodule

/* rename/rename_table.sv */
// register alias table with physical ready bits and in-bundle forwarding
`timescale 1ns/1ps

module rename_table (
  input  logic                                           clk,
  input  logic                                           rst_n,
  input  sched_pkg::sched_req_t                          lookup_i,
  input  sched_pkg::preg_t [sched_pkg::DECODE_WIDTH-1:0] new_preg_i,
  input  logic                                           commit_i,
  output sched_pkg::preg_t [sched_pkg::DECODE_WIDTH-1:0] psrc0_o,
  output sched_pkg::preg_t [sched_pkg::DECODE_WIDTH-1:0] psrc1_o,
  output logic [sched_pkg::DECODE_WIDTH-1:0]             src0_rdy_o,
  output logic [sched_pkg::DECODE_WIDTH-1:0]             src1_rdy_o,
  output sched_pkg::preg_t [sched_pkg::DECODE_WIDTH-1:0] old_pdest_o,
  input  sched_pkg::wb_t                                 wb_i
);
  import sched_pkg::*;

  preg_t [NUM_ARCH_REGS-1:0] map_q;
  logic [NUM_PHYS_REGS-1:0]  ready_q;
  logic [DECODE_WIDTH-1:0]   dest_wr;

  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      dest_wr[i]     = lookup_i[i].valid && (lookup_i[i].dest != '0);
      psrc0_o[i]     = map_q[lookup_i[i].src0];
      psrc1_o[i]     = map_q[lookup_i[i].src1];
      old_pdest_o[i] = map_q[lookup_i[i].dest];
      src0_rdy_o[i]  = ready_q[psrc0_o[i]];
      src1_rdy_o[i]  = ready_q[psrc1_o[i]];

      // older lanes of the same bundle override the table, youngest wins
      for (int j = 0; j < i; j++) begin
        if (dest_wr[j] && (lookup_i[j].dest == lookup_i[i].src0)) begin
          psrc0_o[i]    = new_preg_i[j];
          src0_rdy_o[i] = 1'b0;
        end
        if (dest_wr[j] && (lookup_i[j].dest == lookup_i[i].src1)) begin
          psrc1_o[i]    = new_preg_i[j];
          src1_rdy_o[i] = 1'b0;
        end
        if (dest_wr[j] && (lookup_i[j].dest == lookup_i[i].dest)) begin
          old_pdest_o[i] = new_preg_i[j];
        end
      end
    end
  end

  // ====================
  // table update
  // ====================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < NUM_ARCH_REGS; a++) begin
        map_q[a] <= preg_t'(a);
      end
      ready_q <= '1;
    end else begin
      for (int w = 0; w < WB_WIDTH; w++) begin
        if (wb_i[w].valid) begin
          ready_q[wb_i[w].preg] <= 1'b1;
        end
      end
      // new mappings start not ready, later lanes overwrite earlier ones
      if (commit_i) begin
        for (int i = 0; i < DECODE_WIDTH; i++) begin
          if (dest_wr[i]) begin
            map_q[lookup_i[i].dest] <= new_preg_i[i];
            ready_q[new_preg_i[i]]  <= 1'b0;
          end
        end
      end
    end
  end

endmodule

/* rename/rename_stage.sv */
// rename stage: allocate, look up, hold the renamed bundle and route it to the stations
`timescale 1ns/1ps

module rename_stage (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  sched_pkg::sched_req_t                                req_i,
  output logic                                                 req_ready_o,
  input  sched_pkg::wb_t                                       wb_i,
  input  sched_pkg::free_t                                     free_i,
  output logic [sched_pkg::DECODE_WIDTH-1:0]                   alu_wr_valid_o,
  output sched_pkg::alu_payload_t [sched_pkg::DECODE_WIDTH-1:0] alu_wr_o,
  input  logic                                                 alu_wr_ready_i,
  output logic [sched_pkg::DECODE_WIDTH-1:0]                   mem_wr_valid_o,
  output sched_pkg::mem_payload_t [sched_pkg::DECODE_WIDTH-1:0] mem_wr_o,
  input  logic                                                 mem_wr_ready_i
);
  import sched_pkg::*;

  typedef struct packed {
    logic         valid;
    instr_class_e cls;
    rs_base_t     base;
    alu_op_t      alu_op;
    mem_op_t      mem_op;
  } lane_t;

  lane_t [DECODE_WIDTH-1:0] stage_q;
  lane_t [DECODE_WIDTH-1:0] stage_d;
  lane_t [DECODE_WIDTH-1:0] fresh;
  logic [DECODE_WIDTH-1:0]  req_vld;
  logic [DECODE_WIDTH-1:0]  stage_vld;
  logic [DECODE_WIDTH-1:0]  alloc_req;
  logic                     alloc_ok;
  logic                     drain;
  logic                     accept;
  preg_t [DECODE_WIDTH-1:0] alloc_preg;
  preg_t [DECODE_WIDTH-1:0] psrc0;
  preg_t [DECODE_WIDTH-1:0] psrc1;
  preg_t [DECODE_WIDTH-1:0] old_pdest;
  logic [DECODE_WIDTH-1:0]  src0_rdy;
  logic [DECODE_WIDTH-1:0]  src1_rdy;

  // ====================
  // handshake
  // ====================
  assign drain       = alu_wr_ready_i && mem_wr_ready_i;
  assign req_ready_o = alloc_ok && ((stage_vld == '0) || drain);
  assign accept      = req_ready_o && (req_vld != '0);

  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      req_vld[i]   = req_i[i].valid;
      stage_vld[i] = stage_q[i].valid;
      alloc_req[i] = accept && req_i[i].valid && (req_i[i].dest != '0);

      fresh[i].valid           = req_i[i].valid;
      fresh[i].cls             = req_i[i].cls;
      fresh[i].alu_op          = req_i[i].alu_op;
      fresh[i].mem_op          = req_i[i].mem_op;
      fresh[i].base.tag        = req_i[i].tag;
      fresh[i].base.src0_valid = req_i[i].src0 != '0;
      fresh[i].base.psrc0      = psrc0[i];
      fresh[i].base.src0_rdy   = src0_rdy[i];
      fresh[i].base.src1_valid = req_i[i].src1 != '0;
      fresh[i].base.psrc1      = psrc1[i];
      fresh[i].base.src1_rdy   = src1_rdy[i];
      fresh[i].base.dest_valid = req_i[i].dest != '0;
      fresh[i].base.pdest      = (req_i[i].dest != '0) ? alloc_preg[i] : '0;
      fresh[i].base.old_pdest  = old_pdest[i];
    end
  end

  // next bundle, with writeback bypass on both new and held sources
  always_comb begin
    if (accept) begin
      stage_d = fresh;
    end else if (drain) begin
      stage_d = '0;
    end else begin
      stage_d = stage_q;
    end
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      for (int w = 0; w < WB_WIDTH; w++) begin
        if (wb_i[w].valid && (stage_d[i].base.psrc0 == wb_i[w].preg)) begin
          stage_d[i].base.src0_rdy = 1'b1;
        end
        if (wb_i[w].valid && (stage_d[i].base.psrc1 == wb_i[w].preg)) begin
          stage_d[i].base.src1_rdy = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_q <= '0;
    end else begin
      stage_q <= stage_d;
    end
  end

  // ====================
  // routing by class
  // ====================
  always_comb begin
    int unsigned na;
    int unsigned nm;
    na             = 0;
    nm             = 0;
    alu_wr_valid_o = '0;
    alu_wr_o       = '0;
    mem_wr_valid_o = '0;
    mem_wr_o       = '0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (stage_q[i].valid && drain) begin
        if (stage_q[i].cls == CLASS_MEM) begin
          mem_wr_valid_o[nm] = 1'b1;
          mem_wr_o[nm].base  = stage_q[i].base;
          mem_wr_o[nm].op    = stage_q[i].mem_op;
          nm++;
        end else begin
          alu_wr_valid_o[na] = 1'b1;
          alu_wr_o[na].base  = stage_q[i].base;
          alu_wr_o[na].op    = stage_q[i].alu_op;
          na++;
        end
      end
    end
  end

  free_list u_free_list (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_req_i  (alloc_req),
    .alloc_ok_o   (alloc_ok),
    .alloc_preg_o (alloc_preg),
    .free_i       (free_i)
  );

  rename_table u_rename_table (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookup_i    (req_i),
    .new_preg_i  (alloc_preg),
    .commit_i    (accept),
    .psrc0_o     (psrc0),
    .psrc1_o     (psrc1),
    .src0_rdy_o  (src0_rdy),
    .src1_rdy_o  (src1_rdy),
    .old_pdest_o (old_pdest),
    .wb_i        (wb_i)
  );

endmodule

/* hdl/reservation_station.sv */
// reservation station with wakeup and oldest-first or in-order selection
`timescale 1ns/1ps

module reservation_station #(
  parameter int  DEPTH     = 4,
  parameter bit  IN_ORDER  = 1'b0,
  parameter type PAYLOAD_T = sched_pkg::alu_payload_t
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [sched_pkg::DECODE_WIDTH-1:0]     wr_valid_i,
  input  PAYLOAD_T [sched_pkg::DECODE_WIDTH-1:0] wr_data_i,
  output logic                                   wr_ready_o,
  input  sched_pkg::wb_t                         wb_i,
  input  logic                                   issue_ready_i,
  output logic                                   issue_valid_o,
  output PAYLOAD_T                               issue_data_o
);
  import sched_pkg::*;

  // entries are kept compacted, index 0 is the oldest
  PAYLOAD_T [DEPTH-1:0] ent_q;
  PAYLOAD_T [DEPTH-1:0] ent_d;
  logic [DEPTH-1:0]     vld_q;
  logic [DEPTH-1:0]     vld_d;
  logic [DEPTH-1:0]     cand;
  int                   sel_idx;
  logic                 pop;

  // room for a full bundle
  assign wr_ready_o = !vld_q[DEPTH-DECODE_WIDTH];
  assign pop        = issue_valid_o && issue_ready_i;

  // ====================
  // select
  // ====================
  always_comb begin
    for (int e = 0; e < DEPTH; e++) begin
      cand[e] = vld_q[e]
                && (!ent_q[e].base.src0_valid || ent_q[e].base.src0_rdy)
                && (!ent_q[e].base.src1_valid || ent_q[e].base.src1_rdy)
                && (!IN_ORDER || (e == 0));
    end
    // scan young to old so the oldest candidate wins
    issue_valid_o = 1'b0;
    sel_idx       = 0;
    for (int e = DEPTH - 1; e >= 0; e--) begin
      if (cand[e]) begin
        issue_valid_o = 1'b1;
        sel_idx       = e;
      end
    end
    issue_data_o = ent_q[sel_idx];
  end

  // ====================
  // compact, append, wake
  // ====================
  always_comb begin
    int n;
    n     = 0;
    ent_d = ent_q;
    vld_d = '0;
    for (int e = 0; e < DEPTH; e++) begin
      if (vld_q[e] && !(pop && (sel_idx == e))) begin
        ent_d[n] = ent_q[e];
        vld_d[n] = 1'b1;
        n++;
      end
    end
    // new lanes go behind everything already held
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (wr_valid_i[i]) begin
        ent_d[n] = wr_data_i[i];
        vld_d[n] = 1'b1;
        n++;
      end
    end
    for (int e = 0; e < DEPTH; e++) begin
      for (int w = 0; w < WB_WIDTH; w++) begin
        if (wb_i[w].valid && (ent_d[e].base.psrc0 == wb_i[w].preg)) begin
          ent_d[e].base.src0_rdy = 1'b1;
        end
        if (wb_i[w].valid && (ent_d[e].base.psrc1 == wb_i[w].preg)) begin
          ent_d[e].base.src1_rdy = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q <= vld_d;
    end
  end

  always_ff @(posedge clk) begin
    ent_q <= ent_d;
  end

endmodule

/* hdl/sched_top.sv */
// scheduler top: rename stage, ALU and memory stations, registered issue ports
`timescale 1ns/1ps

module sched_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  sched_pkg::sched_req_t   sched_req_i,
  output logic                    sched_ready_o,
  input  sched_pkg::wb_t          wb_i,
  input  sched_pkg::free_t        free_i,
  output logic                    alu_issue_valid_o,
  output sched_pkg::alu_payload_t alu_issue_o,
  input  logic                    alu_ready_i,
  output logic                    mem_issue_valid_o,
  output sched_pkg::mem_payload_t mem_issue_o,
  input  logic                    mem_ready_i
);
  import sched_pkg::*;

  logic [DECODE_WIDTH-1:0]         alu_wr_valid;
  alu_payload_t [DECODE_WIDTH-1:0] alu_wr;
  logic                            alu_wr_ready;
  logic [DECODE_WIDTH-1:0]         mem_wr_valid;
  mem_payload_t [DECODE_WIDTH-1:0] mem_wr;
  logic                            mem_wr_ready;
  logic                            alu_sel_valid;
  alu_payload_t                    alu_sel;
  logic                            mem_sel_valid;
  mem_payload_t                    mem_sel;
  logic                            alu_adv;
  logic                            mem_adv;

  rename_stage u_rename (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (sched_req_i),
    .req_ready_o    (sched_ready_o),
    .wb_i           (wb_i),
    .free_i         (free_i),
    .alu_wr_valid_o (alu_wr_valid),
    .alu_wr_o       (alu_wr),
    .alu_wr_ready_i (alu_wr_ready),
    .mem_wr_valid_o (mem_wr_valid),
    .mem_wr_o       (mem_wr),
    .mem_wr_ready_i (mem_wr_ready)
  );

  reservation_station #(
    .DEPTH     (ALU_RS_DEPTH),
    .IN_ORDER  (1'b0),
    .PAYLOAD_T (alu_payload_t)
  ) alu_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (alu_wr_valid),
    .wr_data_i     (alu_wr),
    .wr_ready_o    (alu_wr_ready),
    .wb_i          (wb_i),
    .issue_ready_i (alu_adv),
    .issue_valid_o (alu_sel_valid),
    .issue_data_o  (alu_sel)
  );

  reservation_station #(
    .DEPTH     (MEM_RS_DEPTH),
    .IN_ORDER  (1'b1),
    .PAYLOAD_T (mem_payload_t)
  ) mem_rs (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (mem_wr_valid),
    .wr_data_i     (mem_wr),
    .wr_ready_o    (mem_wr_ready),
    .wb_i          (wb_i),
    .issue_ready_i (mem_adv),
    .issue_valid_o (mem_sel_valid),
    .issue_data_o  (mem_sel)
  );

  // ====================
  // issue registers
  // ====================
  // load when empty or consumed, otherwise hold the item and the station
  assign alu_adv = !alu_issue_valid_o || alu_ready_i;
  assign mem_adv = !mem_issue_valid_o || mem_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_issue_valid_o <= 1'b0;
      mem_issue_valid_o <= 1'b0;
    end else begin
      if (alu_adv) begin
        alu_issue_valid_o <= alu_sel_valid;
      end
      if (mem_adv) begin
        mem_issue_valid_o <= mem_sel_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alu_adv) begin
      alu_issue_o <= alu_sel;
    end
    if (mem_adv) begin
      mem_issue_o <= mem_sel;
    end
  end

endmodule

/* verif/sched_ref.svh */
// reference model for expected register allocations and source mappings
`ifndef SCHED_REF_SVH
`define SCHED_REF_SVH

// first pops come straight from the reset contents of the free list
function automatic int first_alloc(input int widx);
  return NUM_ARCH_REGS + widx;
endfunction

// later pops hand back freed registers in the order they were freed
function automatic int expected_alloc(input int widx);
  if (widx < FL_DEPTH) begin
    return first_alloc(widx);
  end
  if (widx - FL_DEPTH < freed_seq.size()) begin
    return freed_seq[widx - FL_DEPTH];
  end
  return -1;
endfunction

// most recent instruction older than tag that writes areg
function automatic int last_writer(input int tag, input int areg);
  for (int k = tag - 1; k >= 0; k--) begin
    if (prog_dest[k] == areg) begin
      return k;
    end
  end
  return -1;
endfunction

// physical register that tag must see for areg
// -1 while the writer has not reported its pdest yet
function automatic int expected_map(input int tag, input int areg);
  int w;
  w = last_writer(tag, areg);
  if (w < 0) begin
    return areg;
  end
  if (!issued[w]) begin
    return -1;
  end
  return pdest_seen[w];
endfunction

`endif

/* verif/sched_tb.sv */
// testbench for the scheduler with reference checks on every issued instruction
`timescale 1ns/1ps

module sched_tb;
  import sched_pkg::*;

  // phase boundaries in tag order
  localparam int P_RAND   = 6;
  localparam int P_HOLD   = 126;
  localparam int P_EXH    = 142;
  localparam int NUM_TAGS = 202;

  localparam int BUNDLE_TIMEOUT = 2000;
  localparam int DRAIN_TIMEOUT  = 4000;
  localparam int WAIT_TIMEOUT   = 500;

  typedef struct {
    int tag;
    int preg;
    int due;
  } wb_pend_t;

  logic         clk;
  logic         rst_n;
  sched_req_t   sched_req_i;
  logic         sched_ready_o;
  wb_t          wb_i = '0;
  free_t        free_i = '0;
  logic         alu_issue_valid_o;
  alu_payload_t alu_issue_o;
  logic         alu_ready_i = 1'b0;
  logic         mem_issue_valid_o;
  mem_payload_t mem_issue_o;
  logic         mem_ready_i = 1'b0;

  sched_top dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .sched_req_i       (sched_req_i),
    .sched_ready_o     (sched_ready_o),
    .wb_i              (wb_i),
    .free_i            (free_i),
    .alu_issue_valid_o (alu_issue_valid_o),
    .alu_issue_o       (alu_issue_o),
    .alu_ready_i       (alu_ready_i),
    .mem_issue_valid_o (mem_issue_valid_o),
    .mem_issue_o       (mem_issue_o),
    .mem_ready_i       (mem_ready_i)
  );

  // program and observed state per tag
  bit       prog_mem    [NUM_TAGS];
  bit       prog_solo   [NUM_TAGS];
  int       prog_src0   [NUM_TAGS];
  int       prog_src1   [NUM_TAGS];
  int       prog_dest   [NUM_TAGS];
  int       prog_aop    [NUM_TAGS];
  int       prog_mop    [NUM_TAGS];
  int       widx        [NUM_TAGS];
  bit       issued      [NUM_TAGS];
  bit       wb_done     [NUM_TAGS];
  bit       dvalid_seen [NUM_TAGS];
  int       pdest_seen  [NUM_TAGS];
  int       old_seen    [NUM_TAGS];
  int       freed_seq   [$];
  wb_pend_t wb_pend     [$];

  int cyc         = 0;
  int next_commit = 0;
  int last_mem    = -1;
  int rdy_mode    = 0;
  bit hold_frees  = 1'b0;
  // destinations taken by accepted bundles
  int allocs      = 0;
  int checks      = 0;
  int errors      = 0;

  `include "sched_ref.svh"

  task automatic report_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string msg);
    $display("run stopped: %s", msg);
    $display("checks %0d, errors %0d", checks, errors);
    $display("RESULT: FAIL");
    $finish;
  endtask

  task automatic print_test(input int num, input string name, input int e0);
    $display("test %0d %s: %s, %0d errors", num, name,
             (errors == e0) ? "ok" : "failed", errors - e0);
  endtask

  task automatic set_instr(input int t, input bit mem, input int s0, input int s1,
                           input int d);
    prog_mem[t]  = mem;
    prog_src0[t] = s0;
    prog_src1[t] = s1;
    prog_dest[t] = d;
    prog_aop[t]  = t % 16;
    prog_mop[t]  = t % 8;
    prog_solo[t] = 1'b0;
  endtask

  task automatic build_program();
    int nw;
    // directed start with an in-bundle dependency and dest-less lanes
    set_instr(0, 1'b0, 0, 0, 1);
    set_instr(1, 1'b0, 1, 2, 3);
    set_instr(2, 1'b1, 3, 0, 0);
    set_instr(3, 1'b0, 4, 0, 4);
    set_instr(4, 1'b1, 1, 4, 5);
    set_instr(5, 1'b0, 5, 5, 0);
    for (int t = P_RAND; t < NUM_TAGS; t++) begin
      prog_mem[t]  = (t < P_HOLD || t >= P_EXH) && ($urandom % 3 == 0);
      prog_src0[t] = int'($urandom % 8);
      prog_src1[t] = int'($urandom % 8);
      prog_dest[t] = (t >= P_EXH) ? 1 + int'($urandom % 7) : int'($urandom % 8);
      prog_aop[t]  = int'($urandom % 16);
      prog_mop[t]  = int'($urandom % 8);
      prog_solo[t] = ($urandom % 5 == 0);
    end
    nw = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      widx[t] = nw;
      if (prog_dest[t] != 0) begin
        nw++;
      end
    end
  endtask

  function automatic sched_instr_t make_instr(input int t);
    sched_instr_t ins;
    ins.valid  = 1'b1;
    ins.cls    = prog_mem[t] ? CLASS_MEM : CLASS_ALU;
    ins.src0   = areg_t'(prog_src0[t]);
    ins.src1   = areg_t'(prog_src1[t]);
    ins.dest   = areg_t'(prog_dest[t]);
    ins.alu_op = alu_op_t'(prog_aop[t]);
    ins.mem_op = mem_op_t'(prog_mop[t]);
    ins.tag    = TAG_W'(t);
    return ins;
  endfunction

  // ====================
  // stimulus
  // ====================
  task automatic send_bundles(input int first, input int last);
    int  t;
    int  n;
    int  waited;
    bit  taken;
    t = first;
    while (t < last) begin
      n = (prog_solo[t] || (t + 1 >= last)) ? 1 : 2;
      @(negedge clk);
      sched_req_i = '0;
      for (int l = 0; l < n; l++) begin
        sched_req_i[l] = make_instr(t + l);
      end
      taken  = 1'b0;
      waited = 0;
      while (!taken) begin
        @(posedge clk);
        taken = sched_ready_o;
        waited++;
        if (!taken && waited > BUNDLE_TIMEOUT) begin
          abort_run($sformatf("bundle at tag %0d was never accepted", t));
        end
      end
      for (int l = 0; l < n; l++) begin
        if (prog_dest[t + l] != 0) begin
          allocs++;
        end
      end
      t += n;
    end
    @(negedge clk);
    sched_req_i = '0;
  endtask

  task automatic wait_commit(input int upto);
    int waited;
    waited = 0;
    while (next_commit < upto) begin
      @(posedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        abort_run($sformatf("only %0d of %0d tags committed in time", next_commit, upto));
      end
    end
  endtask

  // hold the alu port while a payload waits, then release it
  task automatic check_alu_hold();
    alu_payload_t held;
    int           waited;
    waited = 0;
    @(posedge clk);
    while (!alu_issue_valid_o) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_TIMEOUT) begin
        abort_run("no ALU issue appeared while the ALU port was held");
      end
    end
    held = alu_issue_o;
    repeat (12) begin
      @(posedge clk);
      checks++;
      if (!alu_issue_valid_o || (alu_issue_o != held)) begin
        report_err("ALU issue payload changed under back-pressure");
      end
    end
    rdy_mode = 0;
  endtask

  // frees are withheld, so the free list must run dry
  task automatic check_ready_drop();
    int waited;
    waited = 0;
    while (FL_DEPTH - allocs + freed_seq.size() >= DECODE_WIDTH) begin
      @(posedge clk);
      waited++;
      if (waited > WAIT_TIMEOUT) begin
        abort_run("free list never ran dry while frees were withheld");
      end
    end
    repeat (8) begin
      @(posedge clk);
      checks++;
      if (sched_ready_o) begin
        report_err("sched_ready_o high with the free list exhausted");
      end
    end
    hold_frees = 1'b0;
  endtask

  // ====================
  // issue checks
  // ====================
  task automatic check_src(input int t, input int areg, input logic vld, input logic rdy,
                           input int preg);
    int w;
    int exp;
    checks++;
    if (vld != (areg != 0)) begin
      report_err($sformatf("tag %0d source valid %0b for arch reg %0d", t, vld, areg));
    end
    if (areg != 0) begin
      if (!rdy) begin
        report_err($sformatf("tag %0d issued with arch reg %0d not ready", t, areg));
      end
      w = last_writer(t, areg);
      if ((w >= 0) && !wb_done[w]) begin
        report_err($sformatf("tag %0d issued before producer tag %0d wrote back", t, w));
      end
      exp = expected_map(t, areg);
      if (preg != exp) begin
        report_err($sformatf("tag %0d arch reg %0d mapped to %0d, expected %0d",
                             t, areg, preg, exp));
      end
    end
  endtask

  task automatic check_issue(input rs_base_t b, input int op, input bit is_mem);
    int       t;
    int       exp;
    wb_pend_t p;
    t = int'(b.tag);
    checks++;
    if (t >= NUM_TAGS) begin
      report_err($sformatf("issued tag %0d was never sent", t));
      return;
    end
    if (issued[t]) begin
      report_err($sformatf("tag %0d issued twice", t));
      return;
    end
    if (prog_mem[t] != is_mem) begin
      report_err($sformatf("tag %0d issued on the wrong station", t));
    end
    if (op != (is_mem ? prog_mop[t] : prog_aop[t])) begin
      report_err($sformatf("tag %0d carries op %0d", t, op));
    end
    if (b.dest_valid != (prog_dest[t] != 0)) begin
      report_err($sformatf("tag %0d dest valid %0b, dest %0d", t, b.dest_valid, prog_dest[t]));
    end
    if (b.dest_valid) begin
      exp = expected_alloc(widx[t]);
      if (int'(b.pdest) != exp) begin
        report_err($sformatf("tag %0d pdest %0d, expected %0d", t, b.pdest, exp));
      end
    end
    check_src(t, prog_src0[t], b.src0_valid, b.src0_rdy, int'(b.psrc0));
    check_src(t, prog_src1[t], b.src1_valid, b.src1_rdy, int'(b.psrc1));
    if (is_mem) begin
      if (t < last_mem) begin
        report_err($sformatf("memory tag %0d issued after tag %0d", t, last_mem));
      end
      last_mem = t;
    end
    issued[t]      = 1'b1;
    dvalid_seen[t] = b.dest_valid;
    pdest_seen[t]  = int'(b.pdest);
    old_seen[t]    = int'(b.old_pdest);
    if (b.dest_valid) begin
      p.tag  = t;
      p.preg = int'(b.pdest);
      p.due  = cyc + 1 + int'($urandom % 4);
      wb_pend.push_back(p);
    end else begin
      wb_done[t] = 1'b1;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // execution and commit model, driven on the falling edge
  always @(negedge clk) begin : drive_exec
    wb_t      wb_nxt;
    free_t    free_nxt;
    wb_pend_t keep [$];
    int       nw;
    int       nf;
    int       nc;
    int       t;
    int       exp;
    wb_nxt   = '0;
    free_nxt = '0;
    keep     = {};
    nw       = 0;
    foreach (wb_pend[i]) begin
      if ((nw < WB_WIDTH) && (wb_pend[i].due <= cyc)) begin
        wb_nxt[nw].valid        = 1'b1;
        wb_nxt[nw].preg         = preg_t'(wb_pend[i].preg);
        wb_done[wb_pend[i].tag] = 1'b1;
        nw++;
      end else begin
        keep.push_back(wb_pend[i]);
      end
    end
    wb_pend = keep;

    // in-order commit frees the previous mapping of the dest
    nf = 0;
    nc = 0;
    while (!hold_frees && (nc < COMMIT_WIDTH) && (next_commit < NUM_TAGS)
           && issued[next_commit] && wb_done[next_commit]) begin
      t = next_commit;
      if (dvalid_seen[t]) begin
        exp = expected_map(t, prog_dest[t]);
        checks++;
        if (old_seen[t] != exp) begin
          report_err($sformatf("tag %0d old pdest %0d, expected %0d", t, old_seen[t], exp));
        end
        free_nxt[nf].valid = 1'b1;
        free_nxt[nf].preg  = preg_t'(old_seen[t]);
        freed_seq.push_back(old_seen[t]);
        nf++;
      end
      next_commit++;
      nc++;
    end

    wb_i        = wb_nxt;
    free_i      = free_nxt;
    alu_ready_i = (rdy_mode == 1) ? 1'b0 : (($urandom % 4) != 0);
    mem_ready_i = ($urandom % 4) != 0;
  end

  // compare every transfer on the issue ports
  always @(posedge clk) begin : compare_issue
    if (rst_n) begin
      cyc++;
      if (alu_issue_valid_o && alu_ready_i) begin
        check_issue(alu_issue_o.base, int'(alu_issue_o.op), 1'b0);
      end
      if (mem_issue_valid_o && mem_ready_i) begin
        check_issue(mem_issue_o.base, int'(mem_issue_o.op), 1'b1);
      end
    end
  end

  // ====================
  // test sequence
  // ====================
  initial begin : run
    int e0;
    void'($urandom(32'h205c_7886));
    rst_n       = 1'b0;
    sched_req_i = '0;
    build_program();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    e0 = errors;
    @(posedge clk);
    checks++;
    if (alu_issue_valid_o || mem_issue_valid_o) begin
      report_err("issue valid high after reset");
    end
    checks++;
    if (!sched_ready_o) begin
      report_err("sched_ready_o low after reset");
    end
    print_test(1, "reset state", e0);

    e0 = errors;
    send_bundles(0, P_RAND);
    wait_commit(P_RAND);
    foreach (pdest_seen[t]) begin
      if ((t < P_RAND) && (prog_dest[t] != 0)) begin
        checks++;
        if (pdest_seen[t] != first_alloc(widx[t])) begin
          report_err($sformatf("tag %0d first allocation %0d", t, pdest_seen[t]));
        end
      end
    end
    checks++;
    if (dvalid_seen[2] || dvalid_seen[5]) begin
      report_err("lane without dest reported dest valid");
    end
    print_test(2, "first allocations", e0);

    e0 = errors;
    send_bundles(P_RAND, P_HOLD);
    wait_commit(P_HOLD);
    print_test(3, "renaming and wakeup", e0);

    e0 = errors;
    rdy_mode = 1;
    fork
      send_bundles(P_HOLD, P_EXH);
      check_alu_hold();
    join
    wait_commit(P_EXH);
    print_test(4, "issue back-pressure", e0);

    e0 = errors;
    hold_frees = 1'b1;
    fork
      send_bundles(P_EXH, NUM_TAGS);
      check_ready_drop();
    join
    wait_commit(NUM_TAGS);
    print_test(5, "free list exhaustion", e0);

    // every tag is consumed, so nothing may show up on either port
    e0 = errors;
    repeat (8) begin
      @(posedge clk);
      checks++;
      if (alu_issue_valid_o || mem_issue_valid_o) begin
        report_err("issue valid high after every tag had issued");
      end
    end
    print_test(6, "every tag issued once", e0);

    $display("tests 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+verif
common/sched_pkg.sv
rename/free_list.sv
rename/rename_table.sv
rename/rename_stage.sv
hdl/reservation_station.sv
hdl/sched_top.sv
verif/sched_tb.sv

/* Makefile */
# Verilator flow for the scheduler testbench

VERILATOR ?= verilator
TOP       ?= sched_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# pass only when the pass line shows up in the simulation output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
